/* include/ppc_macros.svh */
// **************************************
// PPC program error path constants
// SPR numbers, MSR/ESR bits, opcodes
// **************************************
`ifndef PPC_MACROS_SVH
`define PPC_MACROS_SVH

`define SPRN_XER    10'd1
`define SPRN_LR     10'd8
`define SPRN_CTR    10'd9
`define SPRN_SRR0   10'd26
`define SPRN_SRR1   10'd27
`define SPRN_DEAR   10'd61
`define SPRN_ESR    10'd62
`define SPRN_IVPR   10'd63
`define SPRN_IVOR2  10'd402
`define SPRN_IVOR3  10'd403
`define SPRN_IVOR4  10'd404
`define SPRN_IVOR6  10'd406
`define SPRN_IVOR8  10'd408
`define SPRN_IVOR13 10'd413
`define SPRN_IVOR14 10'd414

`define MSR_EE  16 // big-endian bit numbers
`define MSR_PR  17

`define ESR_PIL 4
`define ESR_PPR 5
`define ESR_PTR 6

`define OP_PRIMARY_TWI 6'd3
`define OP_PRIMARY_X   6'd31

`define XO_TW    10'd4
`define XO_MFMSR 10'd83
`define XO_MTMSR 10'd146
`define XO_ADD   10'd266
`define XO_MFSPR 10'd339
`define XO_OR    10'd444
`define XO_MTSPR 10'd467

`endif

/* hdl/ppcPkg.sv */
// **************************************
// PPC program error types
// classes, FSM states, stage structs
// **************************************
package ppcPkg;

	typedef enum logic [2:0] {
		OP_NORMAL  = 3'd0,
		OP_UNDEF   = 3'd1,
		OP_PRIV    = 3'd2,
		OP_MOVESPR = 3'd3,
		OP_TRAP    = 3'd4
	} opClass_t;

	typedef enum logic [1:0] {
		EXC_IDLE   = 2'd0,
		EXC_SAVE   = 2'd1,
		EXC_VECTOR = 2'd2
	} excState_t;

	typedef struct packed {
		logic        valid;
		opClass_t    cls;
		logic [9:0]  sprn;      // already swapped
		logic        trapTaken;
		logic [31:0] pc;
		logic [31:0] msr;
	} decodedInstr_t;

	typedef struct packed {
		logic illegal;
		logic privileged;
		logic trap;
	} progErrCode_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] msr;
	} progErrCtx_t;

endpackage

/* hdl/instrDecode.sv */
// **************************************
// Instruction decode stage
// classifies the word, evaluates tw/twi
// **************************************
`timescale 1ns/1ps
`include "ppc_macros.svh"

module instrDecode import ppcPkg::*; (
	input  logic          clk,
	input  logic          rst,
	input  logic          instrValid,
	input  logic [31:0]   instr,
	input  logic [31:0]   pc,
	input  logic [31:0]   msr,
	input  logic [31:0]   rA,
	input  logic [31:0]   rB,
	input  logic          flush,
	output decodedInstr_t dec
);

	logic [5:0]  primary;
	logic [9:0]  xo;
	logic [4:0]  to;
	logic [31:0] cmpB;
	logic        lessS;
	logic        greaterS;
	logic        equal;
	logic        lessU;
	logic        greaterU;
	logic        trapHit;
	logic        take;
	opClass_t    cls;

	assign primary = instr[31:26];
	assign to      = instr[25:21];
	assign xo      = instr[10:1];
	assign take    = instrValid & ~flush; // dropped during exception service

	// twi compares against the sign-extended SI field
	assign cmpB = (primary == `OP_PRIMARY_TWI) ? {{16{instr[15]}}, instr[15:0]} : rB;

	assign lessS    = $signed(rA) < $signed(cmpB);
	assign greaterS = $signed(rA) > $signed(cmpB);
	assign equal    = rA == cmpB;
	assign lessU    = rA < cmpB;
	assign greaterU = rA > cmpB;

	assign trapHit = (to[4] & lessS) |
	                 (to[3] & greaterS) |
	                 (to[2] & equal) |
	                 (to[1] & lessU) |
	                 (to[0] & greaterU);

	always_comb begin
		cls = OP_UNDEF;
		if (primary == `OP_PRIMARY_TWI) begin
			cls = OP_TRAP;
		end else if (primary == `OP_PRIMARY_X) begin
			case (xo)
				`XO_ADD, `XO_OR:      cls = OP_NORMAL;
				`XO_MTMSR, `XO_MFMSR: cls = OP_PRIV;
				`XO_MTSPR, `XO_MFSPR: cls = OP_MOVESPR;
				`XO_TW:               cls = OP_TRAP;
				default:              cls = OP_UNDEF;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			dec.valid <= 1'b0;
		end else begin
			dec.valid <= take;
		end
		if (take) begin
			dec.cls       <= cls;
			dec.sprn      <= {instr[15:11], instr[20:16]}; // split field swap
			dec.trapTaken <= trapHit;
			dec.pc        <= pc;
			dec.msr       <= msr;
		end
	end

	// nothing leaves decode on the cycle after a flush
	noValidAfterFlush: assert property (@(posedge clk) disable iff (rst)
		$past(flush) |-> !dec.valid)
		else $error("decode emitted a valid item after flush");

endmodule

/* hdl/programError.sv */
// **************************************
// Program error detection
// sticky request for illegal/priv/trap
// **************************************
`timescale 1ns/1ps
`include "ppc_macros.svh"

module programError import ppcPkg::*; (
	input  logic          clk,
	input  logic          rst,
	input  decodedInstr_t dec,
	input  logic          ack,
	output logic          progErr,
	output progErrCode_t  code,
	output progErrCtx_t   ctx
);

	// result is {exists, privileged}
	function automatic logic [1:0] sprLookup(input logic [9:0] sprn);
		case (sprn)
			`SPRN_XER, `SPRN_LR, `SPRN_CTR:
				sprLookup = 2'b10;
			`SPRN_SRR0, `SPRN_SRR1, `SPRN_ESR, `SPRN_DEAR, `SPRN_IVPR,
			`SPRN_IVOR2, `SPRN_IVOR3, `SPRN_IVOR4, `SPRN_IVOR6,
			`SPRN_IVOR8, `SPRN_IVOR13, `SPRN_IVOR14:
				sprLookup = 2'b11;
			default:
				sprLookup = 2'b00;
		endcase
	endfunction

	logic [1:0]   sprInfo;
	logic         problemState;
	logic         isMove;
	logic         req;
	logic         capture;
	progErrCode_t errNow;

	assign sprInfo      = sprLookup(dec.sprn);
	assign problemState = dec.msr[31-`MSR_PR];
	assign isMove       = dec.cls == OP_MOVESPR;

	assign errNow.illegal    = (dec.cls == OP_UNDEF) || (problemState && isMove && !sprInfo[1]);
	assign errNow.privileged = problemState && ((dec.cls == OP_PRIV) || (isMove && sprInfo[0]));
	assign errNow.trap       = (dec.cls == OP_TRAP) && dec.trapTaken;

	assign req     = dec.valid && (|errNow);
	assign capture = req && !progErr && !ack; // first error only

	always_ff @(posedge clk) begin
		if (rst) begin
			progErr <= 1'b0;
		end else if (ack) begin
			progErr <= 1'b0;
		end else if (req) begin
			progErr <= 1'b1;
		end
		if (capture) begin
			code    <= errNow;
			ctx.pc  <= dec.pc;
			ctx.msr <= dec.msr;
		end
	end

	ackOnlyWithRequest: assert property (@(posedge clk) disable iff (rst)
		ack |-> progErr)
		else $error("ack seen without a pending program error");

endmodule

/* hdl/exceptionUnit.sv */
// **************************************
// Program exception unit
// saves context, sets ESR, vectors fetch
// **************************************
`timescale 1ns/1ps
`include "ppc_macros.svh"

module exceptionUnit import ppcPkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         progErr,
	input  progErrCode_t code,
	input  progErrCtx_t  ctx,
	input  logic [31:0]  ivpr,
	input  logic [31:0]  ivor6,
	output logic         ack,
	output logic         flush,
	output logic         redirect,
	output logic [31:0]  redirectPc,
	output logic [31:0]  srr0,
	output logic [31:0]  srr1,
	output logic [31:0]  esr,
	output logic [31:0]  msrNew
);

	excState_t   state;
	logic        takeExc;
	logic [31:0] causeBits;
	logic [31:0] msrCleared;

	assign takeExc = (state == EXC_IDLE) && progErr;

	always_comb begin
		causeBits = '0;
		causeBits[31-`ESR_PIL] = code.illegal;
		causeBits[31-`ESR_PPR] = code.privileged;
		causeBits[31-`ESR_PTR] = code.trap;

		msrCleared = ctx.msr;
		msrCleared[31-`MSR_PR] = 1'b0; // back to supervisor
		msrCleared[31-`MSR_EE] = 1'b0; // external interrupts off
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= EXC_IDLE;
		end else begin
			case (state)
				EXC_IDLE: begin
					if (progErr)
						state <= EXC_SAVE;
				end
				EXC_SAVE:   state <= EXC_VECTOR;
				EXC_VECTOR: state <= EXC_IDLE;
				default:    state <= EXC_IDLE;
			endcase
		end
	end

	// context lands on the edge that enters SAVE
	always_ff @(posedge clk) begin
		if (rst) begin
			srr0   <= '0;
			srr1   <= '0;
			esr    <= '0;
			msrNew <= '0;
		end else if (takeExc) begin
			srr0   <= ctx.pc;
			srr1   <= ctx.msr;
			esr    <= causeBits; // old causes dropped
			msrNew <= msrCleared;
		end
	end

	always_ff @(posedge clk) begin
		if (state == EXC_SAVE)
			redirectPc <= {ivpr[31:16], ivor6[15:4], 4'b0000};
	end

	assign ack      = state == EXC_SAVE;
	assign redirect = state == EXC_VECTOR;
	assign flush    = progErr || (state != EXC_IDLE);

	// one redirect pulse right after each ack
	redirectAfterAck: assert property (@(posedge clk) disable iff (rst)
		ack |=> redirect ##1 !redirect)
		else $error("redirect did not follow ack as a single pulse");

endmodule

/* hdl/progExcTop.sv */
// **************************************
// Program exception path top level
// decode, detection, exception unit
// **************************************
`timescale 1ns/1ps

module progExcTop import ppcPkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        instrValid,
	input  logic [31:0] instr,
	input  logic [31:0] pc,
	input  logic [31:0] msr,
	input  logic [31:0] rA,
	input  logic [31:0] rB,
	input  logic [31:0] ivpr,
	input  logic [31:0] ivor6,
	output logic        redirect,
	output logic [31:0] redirectPc,
	output logic [31:0] srr0,
	output logic [31:0] srr1,
	output logic [31:0] esr,
	output logic [31:0] msrNew,
	output logic        progErr,
	output logic        flush
);

	decodedInstr_t dec;
	progErrCode_t  code;
	progErrCtx_t   ctx;
	logic          ack;

	instrDecode u_decode (
		.clk(clk), .rst(rst), .instrValid(instrValid), .instr(instr),
		.pc(pc), .msr(msr), .rA(rA), .rB(rB), .flush(flush), .dec(dec)
	);

	programError u_progError (
		.clk(clk), .rst(rst), .dec(dec), .ack(ack),
		.progErr(progErr), .code(code), .ctx(ctx)
	);

	exceptionUnit u_excUnit (
		.clk(clk), .rst(rst), .progErr(progErr), .code(code), .ctx(ctx),
		.ivpr(ivpr), .ivor6(ivor6), .ack(ack), .flush(flush),
		.redirect(redirect), .redirectPc(redirectPc),
		.srr0(srr0), .srr1(srr1), .esr(esr), .msrNew(msrNew)
	);

endmodule

/* bench/tbProgExc.sv */
// **************************************
// Program exception path testbench
// directed and random instruction checks
// **************************************
`timescale 1ns/1ps
`include "ppc_macros.svh"

module tbProgExc;

	localparam int NUM_INSTR   = 34;
	localparam int CYCLE_LIMIT = 8 * NUM_INSTR + 50;
	localparam logic [31:0] PR_MASK  = 32'h8000_0000 >> `MSR_PR;
	localparam logic [31:0] EE_MASK  = 32'h8000_0000 >> `MSR_EE;
	localparam logic [31:0] MSR_USER = PR_MASK | EE_MASK | 32'h0000_0030;
	localparam logic [31:0] MSR_SUPV = EE_MASK | 32'h0000_1030;

	logic        clk, rst, instrValid;
	logic [31:0] instr, pc, msr, rA, rB, ivpr, ivor6;
	logic        redirect, progErr, flush;
	logic [31:0] redirectPc, srr0, srr1, esr, msrNew;

	string       testName = "reset";
	logic        expExc = 1'b0;
	logic [2:0]  expCause; // illegal, privileged, trap
	logic [31:0] expPc, expMsr, expMsrNew, expEsr, expVec;
	logic [31:0] nextPc = 32'h0000_1000;
	int          errors = 0;
	int          cycles = 0;
	integer      seed = 95;

	progExcTop u_progExcTop (
		.clk(clk), .rst(rst), .instrValid(instrValid), .instr(instr), .pc(pc), .msr(msr),
		.rA(rA), .rB(rB), .ivpr(ivpr), .ivor6(ivor6), .redirect(redirect),
		.redirectPc(redirectPc), .srr0(srr0), .srr1(srr1), .esr(esr), .msrNew(msrNew),
		.progErr(progErr), .flush(flush)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the instruction sequence never finished", cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	task automatic flagMismatch(input string what, input logic [31:0] expVal,
			input logic [31:0] actVal);
		errors++;
		$display("CHECK FAILED %s (%s): expected %h actual %h", testName, what, expVal, actVal);
	endtask

	// spr number is stored as two swapped halves
	function automatic logic [31:0] xForm(input logic [9:0] xo, input logic [9:0] spr);
		xForm = {`OP_PRIMARY_X, 5'd3, spr[4:0], spr[9:5], xo, 1'b0};
	endfunction

	// expected cause from the program error rules
	function automatic logic [2:0] causeFor(input logic [31:0] word, input logic [31:0] msrIn,
			input logic [31:0] a, input logic [31:0] b);
		logic [5:0]  op;
		logic [9:0]  xo;
		logic [9:0]  spr;
		logic [4:0]  to;
		logic [31:0] bv;
		logic        pr, hit, userSpr, privSpr;
		op  = word[31:26];
		xo  = word[10:1];
		spr = {word[15:11], word[20:16]};
		to  = word[25:21];
		pr  = |(msrIn & PR_MASK);
		bv  = (op == `OP_PRIMARY_TWI) ? {{16{word[15]}}, word[15:0]} : b;
		hit = (to[4] && $signed(a) < $signed(bv)) || (to[3] && $signed(a) > $signed(bv)) ||
		      (to[2] && a == bv) || (to[1] && a < bv) || (to[0] && a > bv);
		userSpr = spr inside {`SPRN_XER, `SPRN_LR, `SPRN_CTR};
		privSpr = spr inside {`SPRN_SRR0, `SPRN_SRR1, `SPRN_ESR, `SPRN_DEAR, `SPRN_IVPR,
			`SPRN_IVOR2, `SPRN_IVOR3, `SPRN_IVOR4, `SPRN_IVOR6, `SPRN_IVOR8,
			`SPRN_IVOR13, `SPRN_IVOR14};
		if (op == `OP_PRIMARY_TWI || (op == `OP_PRIMARY_X && xo == `XO_TW))
			causeFor = {2'b00, hit};
		else if (op == `OP_PRIMARY_X && (xo == `XO_ADD || xo == `XO_OR))
			causeFor = 3'b000;
		else if (op == `OP_PRIMARY_X && (xo == `XO_MTMSR || xo == `XO_MFMSR))
			causeFor = {1'b0, pr, 1'b0};
		else if (op == `OP_PRIMARY_X && (xo == `XO_MTSPR || xo == `XO_MFSPR))
			causeFor = {pr && !userSpr && !privSpr, pr && privSpr, 1'b0};
		else
			causeFor = 3'b100; // unknown opcode
	endfunction

	task automatic issueInstr(input string name, input logic [31:0] word,
			input logic [31:0] msrIn, input logic [31:0] a, input logic [31:0] b);
		@(negedge clk);
		testName  = name;
		expCause  = causeFor(word, msrIn, a, b);
		expExc    = |expCause;
		expPc     = nextPc;
		expMsr    = msrIn;
		expMsrNew = msrIn & ~(PR_MASK | EE_MASK);
		expEsr    = (expCause[2] ? 32'h8000_0000 >> `ESR_PIL : 32'h0) |
		            (expCause[1] ? 32'h8000_0000 >> `ESR_PPR : 32'h0) |
		            (expCause[0] ? 32'h8000_0000 >> `ESR_PTR : 32'h0);
		instr      = word;
		pc         = nextPc;
		msr        = msrIn;
		rA         = a;
		rB         = b;
		instrValid = 1'b1;
		@(negedge clk);
		instrValid = 1'b0;
		nextPc     = nextPc + 32'd4;
		repeat (6) @(negedge clk); // redirect plus one idle cycle fit in here
	endtask

	initial begin
		logic [31:0] a, b, r, msrIn;
		string       mode;
		rst = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		pc = '0;
		msr = '0;
		rA = '0;
		rB = '0;
		ivpr  = 32'h1234_0000;
		ivor6 = 32'hABCD_0A6F; // low nibble must be dropped
		expVec = (ivpr & 32'hFFFF_0000) | (ivor6 & 32'h0000_FFF0);
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int m = 0; m < 2; m++) begin
			msrIn = (m == 0) ? MSR_USER : MSR_SUPV;
			mode  = (m == 0) ? "user" : "supervisor";
			issueInstr({mode, " undef primary"}, 32'h0000_0000, msrIn, 0, 0);
			issueInstr({mode, " undef xo"}, xForm(10'd999, 10'd0), msrIn, 0, 0);
			issueInstr({mode, " mtmsr"}, xForm(`XO_MTMSR, 10'd0), msrIn, 0, 0);
			issueInstr({mode, " mtspr srr0"}, xForm(`XO_MTSPR, `SPRN_SRR0), msrIn, 0, 0);
			issueInstr({mode, " mtspr unlisted"}, xForm(`XO_MTSPR, 10'd500), msrIn, 0, 0);
			issueInstr({mode, " mtspr lr"}, xForm(`XO_MTSPR, `SPRN_LR), msrIn, 0, 0);
		end
		issueInstr("user add", xForm(`XO_ADD, 10'd0), MSR_USER, 0, 0);
		issueInstr("twi equal", {`OP_PRIMARY_TWI, 5'b00100, 5'd4, 16'h0005}, MSR_USER, 5, 0);
		for (int i = 0; i < 20; i++) begin
			a = $random(seed);
			b = $random(seed);
			r = $random(seed);
			if (r[0])
				b = a; // give the equal condition a chance
			issueInstr("tw random", {`OP_PRIMARY_X, r[8:4], 5'd4, 5'd5, `XO_TW, 1'b0},
				r[1] ? MSR_USER : MSR_SUPV, a, b);
		end
		repeat (2) @(negedge clk);
		$display("checks done, errors: %0d", errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	resetFlags: assert property (@(posedge clk) $fell(rst) |-> !redirect && !progErr && !flush)
		else flagMismatch("redirect progErr flush", 0,
			{29'b0, $sampled(redirect), $sampled(progErr), $sampled(flush)});
	resetEsr: assert property (@(posedge clk) $fell(rst) |-> esr == 32'h0)
		else flagMismatch("esr", 0, $sampled(esr));

	redirectOnError: assert property (@(posedge clk) disable iff (rst)
		instrValid && expExc |-> ##4 redirect)
		else flagMismatch("redirect 4 cycles after issue", 1, 0);
	quietWhenLegal: assert property (@(posedge clk) disable iff (rst)
		instrValid && !expExc |-> ##2 !progErr ##2 !redirect)
		else flagMismatch("progErr redirect", 0,
			{30'b0, $sampled(progErr), $sampled(redirect)});

	vectorPc: assert property (@(posedge clk) disable iff (rst) redirect |-> redirectPc == expVec)
		else flagMismatch("redirectPc", expVec, $sampled(redirectPc));
	savedPc: assert property (@(posedge clk) disable iff (rst) redirect |-> srr0 == expPc)
		else flagMismatch("srr0", expPc, $sampled(srr0));
	savedMsr: assert property (@(posedge clk) disable iff (rst) redirect |-> srr1 == expMsr)
		else flagMismatch("srr1", expMsr, $sampled(srr1));
	clearedMsr: assert property (@(posedge clk) disable iff (rst) redirect |-> msrNew == expMsrNew)
		else flagMismatch("msrNew", expMsrNew, $sampled(msrNew));
	causeBits: assert property (@(posedge clk) disable iff (rst) redirect |-> esr == expEsr)
		else flagMismatch("esr", expEsr, $sampled(esr));

endmodule

/* sim.f */
+incdir+include
hdl/ppcPkg.sv
hdl/instrDecode.sv
hdl/programError.sv
hdl/exceptionUnit.sv
hdl/progExcTop.sv
bench/tbProgExc.sv

/* Makefile */
TOP = tbProgExc

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
